//--- n64_ppu.f
source/ppu_pkg.sv
source/n64_vdemux.sv
source/n64_vinfo.sv
source/vmode_resolver.sv
source/ppu_status.sv
source/n64_ppu_top.sv
tests/ppu_tb.sv

//--- source/n64_ppu_top.sv
// Input side of the N64 video pre-processing, all on the N64 pixel clock
// No back-pressure on pixel_o, it is valid for one cycle per pixel

module n64_ppu_top
  import ppu_pkg::*;
(
  input  logic               N64_CLK_i,
  input  logic               reset_i,
  input  logic               nvdsync_i,
  input  logic [COLOR_W-1:0] vd_i,
  input  ppu_cfg_t           cfg_i,
  output pixel_t             pixel_o,
  output logic               pixel_valid_o,
  output ppu_state_t         status_o,
  output logic               scaler_resync_o
);

  sync_t       sync;
  logic        sync_strobe;
  vinfo_t      vinfo;
  video_mode_e video_mode;

  // ==================================================
  // Input path
  // ==================================================

  n64_vdemux vdemux_u (
    .N64_CLK_i     (N64_CLK_i),
    .reset_i       (reset_i),
    .nvdsync_i     (nvdsync_i),
    .vd_i          (vd_i),
    .sync_o        (sync),
    .sync_strobe_o (sync_strobe),
    .n16bit_mode_i (cfg_i.n16bit_mode),
    .pixel_o       (pixel_o),
    .pixel_valid_o (pixel_valid_o)
  );

  n64_vinfo vinfo_u (
    .N64_CLK_i     (N64_CLK_i),
    .reset_i       (reset_i),
    .sync_i        (sync),
    .sync_strobe_i (sync_strobe),
    .vinfo_o       (vinfo)
  );

  // ==================================================
  // Mode and status
  // ==================================================

  vmode_resolver resolver_u (
    .N64_CLK_i    (N64_CLK_i),
    .reset_i      (reset_i),
    .cfg_i        (cfg_i),
    .pal_i        (vinfo.pal),
    .video_mode_o (video_mode)
  );

  ppu_status status_u (
    .N64_CLK_i       (N64_CLK_i),
    .reset_i         (reset_i),
    .vinfo_i         (vinfo),
    .cfg_i           (cfg_i),
    .video_mode_i    (video_mode),
    .status_o        (status_o),
    .scaler_resync_o (scaler_resync_o)
  );

endmodule

//--- source/n64_vdemux.sv
// Expects the N64 order sync, red, green, blue with nvdsync low only in the sync cycle
// Without a new sync phase the demux idles and outputs nothing

module n64_vdemux
  import ppu_pkg::*;
(
  input  logic               N64_CLK_i,
  input  logic               reset_i,
  input  logic               nvdsync_i,
  input  logic [COLOR_W-1:0] vd_i,
  output sync_t              sync_o,
  output logic               sync_strobe_o,
  input  logic               n16bit_mode_i,
  output pixel_t             pixel_o,
  output logic               pixel_valid_o
);

  demux_phase_e       phase;
  logic [COLOR_W-1:0] red_q;
  logic [COLOR_W-1:0] green_q;
  logic [COLOR_W-1:0] color_mask;

  // 16-bit mode drops the two LSBs of every channel
  assign color_mask = {{(COLOR_W-2){1'b1}}, {2{~n16bit_mode_i}}};

  // Phase sequencing and strobes
  always_ff @(posedge N64_CLK_i) begin
    if (reset_i) begin
      phase         <= PH_SYNC;
      sync_strobe_o <= 1'b0;
      pixel_valid_o <= 1'b0;
    end else begin
      sync_strobe_o <= ~nvdsync_i;
      pixel_valid_o <= nvdsync_i && (phase == PH_BLUE);
      if (!nvdsync_i) begin
        phase <= PH_RED;
      end else begin
        case (phase)
          PH_RED:   phase <= PH_GREEN;
          PH_GREEN: phase <= PH_BLUE;
          default:  phase <= PH_SYNC;
        endcase
      end
    end
  end

  // Channel capture
  always_ff @(posedge N64_CLK_i) begin
    if (!nvdsync_i) begin
      sync_o <= sync_t'(vd_i[3:0]);
    end else begin
      case (phase)
        PH_RED:   red_q <= vd_i;
        PH_GREEN: green_q <= vd_i;
        PH_BLUE: begin
          pixel_o.sync  <= sync_o;
          pixel_o.red   <= red_q & color_mask;
          pixel_o.green <= green_q & color_mask;
          pixel_o.blue  <= vd_i & color_mask;
        end
        default: ;
      endcase
    end
  end

endmodule

//--- source/n64_vinfo.sv
// Field length is counted in falling hsyncs between falling vsyncs
// Flags need two falling vsyncs before they mean anything; interlace needs three

module n64_vinfo
  import ppu_pkg::*;
(
  input  logic   N64_CLK_i,
  input  logic   reset_i,
  input  sync_t  sync_i,
  input  logic   sync_strobe_i,
  output vinfo_t vinfo_o
);

  sync_t                 prev_sync;
  logic                  hsync_fall;
  logic                  vsync_fall;
  logic [LINE_CNT_W-1:0] line_cnt;
  logic [LINE_CNT_W-1:0] prev_len;
  logic [1:0]            vsync_cnt;

  // Edges against the previous strobe, only valid while sync_strobe_i is high
  assign hsync_fall = ~sync_i.nhsync & prev_sync.nhsync;
  assign vsync_fall = ~sync_i.nvsync & prev_sync.nvsync;

  always_ff @(posedge N64_CLK_i) begin
    if (reset_i) begin
      prev_sync <= '1;
      line_cnt  <= '0;
      prev_len  <= '0;
      vsync_cnt <= '0;
      vinfo_o   <= '0;
    end else if (sync_strobe_i) begin
      prev_sync <= sync_i;

      if (vsync_fall) begin
        // The falling vsync opens the next field and may carry its first hsync
        line_cnt <= hsync_fall ? LINE_CNT_W'(1) : '0;

        // ==================================================
        // Field end evaluation
        // ==================================================
        if (vsync_cnt != 2'd0) begin
          vinfo_o.pal      <= line_cnt > LINE_CNT_W'(PAL_LINE_THRESHOLD);
          vinfo_o.detected <= 1'b1;
          prev_len         <= line_cnt;
        end
        if (vsync_cnt == 2'd2) begin
          // Alternating field lengths mark an interlaced source
          vinfo_o.interlaced <= line_cnt != prev_len;
        end

        // Saturates once a full field has been seen
        if (vsync_cnt != 2'd2) begin
          vsync_cnt <= vsync_cnt + 2'd1;
        end
      end else if (hsync_fall) begin
        line_cnt <= line_cnt + 1'b1;
      end
    end
  end

endmodule

//--- source/ppu_pkg.sv
// Shared types of the N64 video input path, all fixed by the N64 bus format
// Sync bits are active low, in the order they appear on vd[3:0] in the sync phase

package ppu_pkg;

  // ==================================================
  // Widths and limits
  // ==================================================

  localparam int COLOR_W            = 7;
  localparam int LINE_CNT_W         = 10;
  localparam int PAL_LINE_THRESHOLD = 288;
  localparam int RESYNC_CYCLES      = 4;
  localparam int RESYNC_CNT_W       = $clog2(RESYNC_CYCLES + 1);

  // ==================================================
  // Enums
  // ==================================================

  typedef enum logic [1:0] {
    PH_SYNC,
    PH_RED,
    PH_GREEN,
    PH_BLUE
  } demux_phase_e;

  // Direct covers both 240p and 288p passthrough
  typedef enum logic [2:0] {
    TGT_DIRECT,
    TGT_480P_576P,
    TGT_720P,
    TGT_960P,
    TGT_1080P,
    TGT_1200P,
    TGT_1440P,
    TGT_1440WP
  } target_res_e;

  typedef enum logic [4:0] {
    VM_240P60,
    VM_288P50,
    VM_480P60,
    VM_VGAP60,
    VM_576P50,
    VM_720P60,
    VM_720P50,
    VM_960P60,
    VM_960P50,
    VM_1080P60,
    VM_1080P50,
    VM_1200P60,
    VM_1200P50,
    VM_1440P60,
    VM_1440P50,
    VM_1440WP60,
    VM_1440WP50
  } video_mode_e;

  // ==================================================
  // Packed structs
  // ==================================================

  typedef struct packed {
    logic nvsync;
    logic nclamp;
    logic nhsync;
    logic ncsync;
  } sync_t;

  typedef struct packed {
    sync_t              sync;
    logic [COLOR_W-1:0] red;
    logic [COLOR_W-1:0] green;
    logic [COLOR_W-1:0] blue;
  } pixel_t;

  typedef struct packed {
    logic detected;
    logic pal;
    logic interlaced;
  } vinfo_t;

  // n16bit_mode high means 16-bit colour mode is on
  typedef struct packed {
    target_res_e target;
    logic        use_vga_480p;
    logic        force60;
    logic        force50;
    logic        lowlatency;
    logic        n16bit_mode;
  } ppu_cfg_t;

  typedef struct packed {
    vinfo_t      vinfo;
    logic        n16bit_mode;
    logic        lowlatency;
    target_res_e target;
    video_mode_e video_mode;
  } ppu_state_t;

endpackage

//--- source/ppu_status.sv
// Status word is one register behind its inputs
// Resync pulse restarts on every pal or detected change, even mid-pulse

module ppu_status
  import ppu_pkg::*;
(
  input  logic        N64_CLK_i,
  input  logic        reset_i,
  input  vinfo_t      vinfo_i,
  input  ppu_cfg_t    cfg_i,
  input  video_mode_e video_mode_i,
  output ppu_state_t  status_o,
  output logic        scaler_resync_o
);

  logic                    prev_pal;
  logic                    prev_detected;
  logic                    mode_change;
  logic [RESYNC_CNT_W-1:0] resync_cnt;

  assign mode_change = (vinfo_i.pal ^ prev_pal) | (vinfo_i.detected ^ prev_detected);
  assign scaler_resync_o = resync_cnt != '0;

  always_ff @(posedge N64_CLK_i) begin
    if (reset_i) begin
      status_o            <= '0;
      status_o.video_mode <= VM_480P60;
      prev_pal            <= 1'b0;
      prev_detected       <= 1'b0;
      resync_cnt          <= '0;
    end else begin
      status_o.vinfo       <= vinfo_i;
      status_o.n16bit_mode <= cfg_i.n16bit_mode;
      status_o.lowlatency  <= cfg_i.lowlatency;
      status_o.target      <= cfg_i.target;
      status_o.video_mode  <= video_mode_i;

      prev_pal      <= vinfo_i.pal;
      prev_detected <= vinfo_i.detected;

      // Pulse length counter
      if (mode_change) begin
        resync_cnt <= RESYNC_CNT_W'(RESYNC_CYCLES);
      end else if (scaler_resync_o) begin
        resync_cnt <= resync_cnt - 1'b1;
      end
    end
  end

endmodule

//--- source/vmode_resolver.sv
// Force 50/60 Hz only applies outside low-latency mode and never to the direct target
// Output mode is registered, so it lags cfg_i and pal_i by one cycle

module vmode_resolver
  import ppu_pkg::*;
(
  input  logic        N64_CLK_i,
  input  logic        reset_i,
  input  ppu_cfg_t    cfg_i,
  input  logic        pal_i,
  output video_mode_e video_mode_o
);

  video_mode_e mode_60;
  video_mode_e mode_50;
  logic        force_allowed;
  logic        use_50;

  // ==================================================
  // Candidate modes per refresh rate
  // ==================================================

  always_comb begin
    case (cfg_i.target)
      TGT_DIRECT:    mode_60 = VM_240P60;
      TGT_480P_576P: mode_60 = cfg_i.use_vga_480p ? VM_VGAP60 : VM_480P60;
      TGT_720P:      mode_60 = VM_720P60;
      TGT_960P:      mode_60 = VM_960P60;
      TGT_1080P:     mode_60 = VM_1080P60;
      TGT_1200P:     mode_60 = VM_1200P60;
      TGT_1440P:     mode_60 = VM_1440P60;
      default:       mode_60 = VM_1440WP60;
    endcase
  end

  always_comb begin
    case (cfg_i.target)
      TGT_DIRECT:    mode_50 = VM_288P50;
      TGT_480P_576P: mode_50 = VM_576P50;
      TGT_720P:      mode_50 = VM_720P50;
      TGT_960P:      mode_50 = VM_960P50;
      TGT_1080P:     mode_50 = VM_1080P50;
      TGT_1200P:     mode_50 = VM_1200P50;
      TGT_1440P:     mode_50 = VM_1440P50;
      default:       mode_50 = VM_1440WP50;
    endcase
  end

  // ==================================================
  // Refresh rate selection
  // ==================================================

  assign force_allowed = ~cfg_i.lowlatency && (cfg_i.target != TGT_DIRECT);

  // force60 wins over force50, otherwise follow the source
  always_comb begin
    if (force_allowed && cfg_i.force60) begin
      use_50 = 1'b0;
    end else if (force_allowed && cfg_i.force50) begin
      use_50 = 1'b1;
    end else begin
      use_50 = pal_i;
    end
  end

  always_ff @(posedge N64_CLK_i) begin
    if (reset_i) begin
      video_mode_o <= VM_480P60;
    end else begin
      video_mode_o <= use_50 ? mode_50 : mode_60;
    end
  end

endmodule

//--- tests/ppu_tb.sv
// Directed tests of the N64 video input path with inputs driven on the falling clock edge
// One video line is 8 slots of 4 cycles

module ppu_tb
  import ppu_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 120000;

  logic               n64_clk = 1'b0;
  logic               reset;
  logic               nvdsync;
  logic [COLOR_W-1:0] vd;
  ppu_cfg_t           cfg;
  pixel_t             pixel;
  logic               pixel_valid;
  ppu_state_t         status;
  logic               scaler_resync;

  logic [15:0] lfsr_state = 16'd42722;
  logic        pend_valid = 1'b0;
  pixel_t      pend_pix;
  int          cycle_count = 0;
  int          resync_high = 0;
  int          resync_rises = 0;
  logic        resync_prev = 1'b0;

  n64_ppu_top UUT (
    .N64_CLK_i       (n64_clk),
    .reset_i         (reset),
    .nvdsync_i       (nvdsync),
    .vd_i            (vd),
    .cfg_i           (cfg),
    .pixel_o         (pixel),
    .pixel_valid_o   (pixel_valid),
    .status_o        (status),
    .scaler_resync_o (scaler_resync)
  );

  always #4 n64_clk = ~n64_clk;

  always @(posedge n64_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  // Resync pulse length and number of rising edges
  always @(negedge n64_clk) begin
    if (scaler_resync) resync_high = resync_high + 1;
    if (scaler_resync && !resync_prev) resync_rises = resync_rises + 1;
    resync_prev = scaler_resync;
  end

  // ==================================================
  // Helpers
  // ==================================================

  task automatic check_eq(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
      $display("Checks failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic logic [COLOR_W-1:0] rand_color();
    logic [COLOR_W-1:0] c;
    c = '0;
    for (int i = 0; i < COLOR_W; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      c = {c[COLOR_W-2:0], lfsr_state[0]};
    end
    return c;
  endfunction

  function automatic video_mode_e expected_mode(input ppu_cfg_t c, input logic pal);
    logic rate_50;
    logic can_force;
    int   idx;
    can_force = !c.lowlatency && (c.target != TGT_DIRECT);
    if (can_force && c.force60) rate_50 = 1'b0;
    else if (can_force && c.force50) rate_50 = 1'b1;
    else rate_50 = pal;
    if (c.target == TGT_DIRECT) return rate_50 ? VM_288P50 : VM_240P60;
    if (c.target == TGT_480P_576P) begin
      if (rate_50) return VM_576P50;
      return c.use_vga_480p ? VM_VGAP60 : VM_480P60;
    end
    // Modes from 720p on come in 60/50 pairs in target order
    idx = int'(VM_720P60) + 2 * (int'(c.target) - int'(TGT_720P)) + int'(rate_50);
    return video_mode_e'(idx);
  endfunction

  // Advances to the next falling edge and checks the pixel due after a blue phase
  task automatic next_cycle();
    @(negedge n64_clk);
    check_eq("pixel_valid_o", pixel_valid, pend_valid);
    if (pend_valid) check_eq("pixel_o", pixel, pend_pix);
    pend_valid = 1'b0;
  endtask

  task automatic drive_slot(input sync_t s);
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
    r = rand_color();
    g = rand_color();
    b = rand_color();
    next_cycle();
    nvdsync = 1'b0;
    vd = {3'b000, s};
    next_cycle();
    nvdsync = 1'b1;
    vd = r;
    next_cycle();
    vd = g;
    next_cycle();
    vd = b;
    pend_pix.sync  = s;
    pend_pix.red   = cfg.n16bit_mode ? {r[COLOR_W-1:2], 2'b00} : r;
    pend_pix.green = cfg.n16bit_mode ? {g[COLOR_W-1:2], 2'b00} : g;
    pend_pix.blue  = cfg.n16bit_mode ? {b[COLOR_W-1:2], 2'b00} : b;
    pend_valid = 1'b1;
  endtask

  task automatic drive_field(input int lines);
    sync_t s;
    for (int line = 0; line < lines; line++) begin
      for (int slot = 0; slot < 8; slot++) begin
        s.nvsync = (line != 0);
        s.nhsync = (slot != 0);
        s.nclamp = 1'b1;
        s.ncsync = s.nvsync & s.nhsync;
        drive_slot(s);
      end
    end
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  // ==================================================
  // Tests
  // ==================================================

  task automatic pixel_test();
    repeat (16) drive_slot(sync_t'(4'hF));
    next_cycle();
    cfg.n16bit_mode = 1'b1;
    repeat (16) drive_slot(sync_t'(4'hF));
    next_cycle();
    cfg.n16bit_mode = 1'b0;
    idle(4);
  endtask

  task automatic ntsc_test();
    drive_field(263);
    idle(4);
    check_eq("status_o.vinfo.detected", status.vinfo.detected, 1'b0);
    drive_field(263);
    drive_field(263);
    idle(4);
    check_eq("status_o.vinfo.detected", status.vinfo.detected, 1'b1);
    check_eq("status_o.vinfo.pal", status.vinfo.pal, 1'b0);
    check_eq("status_o.vinfo.interlaced", status.vinfo.interlaced, 1'b0);
  endtask

  task automatic pal_test();
    resync_high = 0;
    resync_rises = 0;
    drive_field(312);
    drive_field(313);
    drive_field(312);
    drive_field(313);
    idle(8);
    check_eq("status_o.vinfo.detected", status.vinfo.detected, 1'b1);
    check_eq("status_o.vinfo.pal", status.vinfo.pal, 1'b1);
    check_eq("status_o.vinfo.interlaced", status.vinfo.interlaced, 1'b1);
    check_eq("scaler_resync_o rises", resync_rises, 1);
    check_eq("scaler_resync_o high cycles", resync_high, RESYNC_CYCLES);
  endtask

  task automatic mode_table_test(input logic pal);
    ppu_cfg_t c;
    for (int t = 0; t < 8; t++) begin
      for (int k = 0; k < 16; k++) begin
        c = '0;
        c.target       = target_res_e'(t);
        c.force60      = k[3];
        c.force50      = k[2];
        c.lowlatency   = k[1];
        c.use_vga_480p = k[0];
        cfg = c;
        idle(2);
        check_eq("status_o.video_mode", status.video_mode, expected_mode(c, pal));
      end
    end
  endtask

  task automatic passthrough_test();
    for (int t = 0; t < 8; t++) begin
      for (int k = 0; k < 4; k++) begin
        cfg.target      = target_res_e'(7 - t);
        cfg.lowlatency  = k[0];
        cfg.n16bit_mode = k[1];
        idle(2);
        check_eq("status_o.target", status.target, cfg.target);
        check_eq("status_o.lowlatency", status.lowlatency, cfg.lowlatency);
        check_eq("status_o.n16bit_mode", status.n16bit_mode, cfg.n16bit_mode);
      end
    end
  endtask

  initial begin
    reset   = 1'b1;
    nvdsync = 1'b1;
    vd      = '0;
    cfg     = '0;
    repeat (3) @(posedge n64_clk);
    @(negedge n64_clk);
    check_eq("pixel_valid_o", pixel_valid, 1'b0);
    check_eq("scaler_resync_o", scaler_resync, 1'b0);
    check_eq("status_o.vinfo", status.vinfo, 3'b000);
    check_eq("status_o.video_mode", status.video_mode, VM_480P60);
    reset = 1'b0;
    idle(2);

    pixel_test();
    ntsc_test();
    mode_table_test(1'b0);
    pal_test();
    mode_table_test(1'b1);
    passthrough_test();

    $display("All checks passed");
    $finish;
  end

endmodule
